/* verilog/swio_pkg.sv */
`default_nettype none

package swio_pkg;

  localparam int NUM_SW = 8;   // Switch cells, one per DIP bit
  localparam int DATA_W = 8;
  localparam int PORT_W = 4;   // Port index width

  // Port offsets within the switched-I/O window
  typedef enum logic [PORT_W-1:0] {
    PORT_ID   = 4'h0,          // Device ID, read inverted
    PORT_CMD  = 4'h1,          // Smart commands
    PORT_VDIP = 4'h2,          // Virtual DIP switches
    PORT_LOCK = 4'h3,
    PORT_LED  = 4'h4,          // Green LED mask
    PORT_PDIP = 4'hC           // Physical DIP, read only
  } port_e;

  // Stored form of the selected device ID
  typedef enum logic [DATA_W-1:0] {
    ID_008_N  = 8'hF7,
    ID_212_N  = 8'h2B,
    ID_NONE_N = 8'hFF
  } dev_id_e;

  // Smart command codes, pairs start on an odd code
  localparam logic [DATA_W-1:0] CMD_LOCK_BASE   = 8'd41;  // Turbo..slot2, five pairs
  localparam logic [DATA_W-1:0] CMD_RSTKEY      = 8'd53;
  localparam logic [DATA_W-1:0] CMD_MAPPER_LOCK = 8'd55;
  localparam logic [DATA_W-1:0] CMD_MEGASD_LOCK = 8'd57;
  localparam logic [DATA_W-1:0] CMD_FULL_LOCK   = 8'd59;
  localparam logic [DATA_W-1:0] CMD_FULL_UNLOCK = 8'd60;
  localparam logic [DATA_W-1:0] CMD_MAP2M_RST   = 8'd251;
  localparam logic [DATA_W-1:0] CMD_WARM_RST    = 8'd252;
  localparam logic [DATA_W-1:0] CMD_MAP4M_RST   = 8'd253;
  localparam logic [DATA_W-1:0] CMD_RESTORE     = 8'd255;

  localparam int BIT_MAPPER = 6;  // Only applied at warm reset
  localparam int BIT_MEGASD = 7;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [PORT_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  // Per-cell request, valid for a single cycle
  typedef struct packed {
    logic set_virt;
    logic virt_val;
    logic set_lock;
    logic lock_val;
    logic restore;   // Reload from the physical switch
  } cell_ctrl_t;

  typedef struct packed {
    logic virt;
    logic lock;
  } cell_state_t;

endpackage

`default_nettype wire

/* verilog/swio_apb_port.sv */
`timescale 1ns/1ps
`default_nettype none

module swio_apb_port (
  input  wire logic                                            clock_bus,
  input  wire logic                                            warmRESET,
  input  wire swio_pkg::apb_req_t                              apb,
  input  wire logic [swio_pkg::DATA_W-1:0]                     dip_sw,
  input  wire swio_pkg::cell_state_t [swio_pkg::NUM_SW-1:0]    cell_state,
  output logic [swio_pkg::DATA_W-1:0]                          prdata,
  output swio_pkg::cell_ctrl_t [swio_pkg::NUM_SW-1:0]          cell_ctrl,
  output logic                                                 warm_req,
  output logic [swio_pkg::DATA_W-1:0]                          led_mask
);

  swio_pkg::dev_id_e                      id_q;       // Selected device, inverted
  logic [swio_pkg::DATA_W-1:0]            cmd_n_q;    // Last command, inverted
  logic [swio_pkg::DATA_W-1:0]            led_q;
  logic [swio_pkg::DATA_W-1:0]            virt_byte;
  logic [swio_pkg::DATA_W-1:0]            lock_byte;
  logic [swio_pkg::DATA_W-1:0]            lock_off;
  logic [$clog2(swio_pkg::NUM_SW)-1:0]    lock_bit;
  logic                                   cmd_lock;   // Single-group lock command
  logic                                   cmd_known;
  logic                                   wr_any;
  logic                                   wr_212;
  swio_pkg::port_e                        port;

  assign port   = swio_pkg::port_e'(apb.paddr);
  assign wr_any = apb.psel && apb.penable && apb.pwrite;   // Access phase, zero wait
  assign wr_212 = wr_any && (id_q == swio_pkg::ID_212_N);
  assign led_mask = led_q;

  // Gather cell state for readback
  always_comb begin
    for (int i = 0; i < swio_pkg::NUM_SW; i++) begin
      virt_byte[i] = cell_state[i].virt;
      lock_byte[i] = cell_state[i].lock;
    end
  end

  // Which lock bit a pair command targets
  always_comb begin
    lock_off = apb.pwdata - swio_pkg::CMD_LOCK_BASE;
    cmd_lock = 1'b1;
    lock_bit = '0;
    if (lock_off < 8'd10) begin
      lock_bit = lock_off[3:1];                           // Turbo to slot2
    end else if (8'(apb.pwdata - swio_pkg::CMD_RSTKEY) < 8'd2) begin
      lock_bit = 3'd5;                                    // Reset key
    end else if (8'(apb.pwdata - swio_pkg::CMD_MAPPER_LOCK) < 8'd2) begin
      lock_bit = 3'(swio_pkg::BIT_MAPPER);
    end else if (8'(apb.pwdata - swio_pkg::CMD_MEGASD_LOCK) < 8'd2) begin
      lock_bit = 3'(swio_pkg::BIT_MEGASD);
    end else begin
      cmd_lock = 1'b0;
    end
  end

  always_comb begin
    cmd_known = cmd_lock;
    case (apb.pwdata)
      swio_pkg::CMD_FULL_LOCK,
      swio_pkg::CMD_FULL_UNLOCK,
      swio_pkg::CMD_MAP2M_RST,
      swio_pkg::CMD_WARM_RST,
      swio_pkg::CMD_MAP4M_RST,
      swio_pkg::CMD_RESTORE:    cmd_known = 1'b1;
      default: ;
    endcase
  end

  // Per-cell controls, one cycle wide
  always_comb begin
    warm_req  = 1'b0;
    cell_ctrl = '0;
    if (wr_212) begin
      case (port)
        swio_pkg::PORT_VDIP: begin
          for (int i = 0; i < swio_pkg::NUM_SW; i++) begin
            cell_ctrl[i].set_virt = 1'b1;
            cell_ctrl[i].virt_val = ~apb.pwdata[i];        // Stored inverted
          end
        end
        swio_pkg::PORT_LOCK: begin
          for (int i = 0; i < swio_pkg::NUM_SW; i++) begin
            cell_ctrl[i].set_lock = 1'b1;
            cell_ctrl[i].lock_val = ~apb.pwdata[i];
          end
        end
        swio_pkg::PORT_CMD: begin
          if (cmd_lock) begin
            cell_ctrl[lock_bit].set_lock = 1'b1;
            cell_ctrl[lock_bit].lock_val = ~apb.pwdata[0];  // Even code locks
          end
          case (apb.pwdata)
            swio_pkg::CMD_FULL_LOCK, swio_pkg::CMD_FULL_UNLOCK: begin
              for (int i = 0; i < swio_pkg::NUM_SW; i++) begin
                cell_ctrl[i].set_lock = 1'b1;
                cell_ctrl[i].lock_val = (apb.pwdata == swio_pkg::CMD_FULL_LOCK);
              end
            end
            swio_pkg::CMD_MAP2M_RST, swio_pkg::CMD_MAP4M_RST: begin
              cell_ctrl[swio_pkg::BIT_MAPPER].set_virt = 1'b1;
              cell_ctrl[swio_pkg::BIT_MAPPER].virt_val =
                (apb.pwdata == swio_pkg::CMD_MAP4M_RST);     // 4 MB mapper
              warm_req = 1'b1;
            end
            swio_pkg::CMD_WARM_RST: warm_req = 1'b1;
            swio_pkg::CMD_RESTORE: begin
              for (int i = 0; i < swio_pkg::NUM_SW; i++) begin
                cell_ctrl[i].restore  = 1'b1;
                cell_ctrl[i].set_lock = 1'b1;                // Unlock everything
                cell_ctrl[i].lock_val = 1'b0;
              end
            end
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock_bus) begin
    if (warmRESET) begin
      id_q    <= swio_pkg::ID_NONE_N;
      cmd_n_q <= '1;
      led_q   <= '0;
    end else begin
      if (wr_any && port == swio_pkg::PORT_ID) begin      // ID select is always open
        case (apb.pwdata)
          8'h08:   id_q <= swio_pkg::ID_008_N;
          8'hD4:   id_q <= swio_pkg::ID_212_N;
          default: id_q <= swio_pkg::ID_NONE_N;
        endcase
      end
      if (wr_212 && port == swio_pkg::PORT_CMD) begin
        cmd_n_q <= cmd_known ? ~apb.pwdata : '1;          // Unknown reads as 0xFF
        if (apb.pwdata == swio_pkg::CMD_RESTORE) led_q <= '0;
      end
      if (wr_212 && port == swio_pkg::PORT_LED) led_q <= ~apb.pwdata;
    end
  end

  // Read mux, valid in the access phase
  always_comb begin
    prdata = '1;
    if (port == swio_pkg::PORT_ID) begin
      prdata = id_q;
    end else if (id_q == swio_pkg::ID_212_N) begin
      case (port)
        swio_pkg::PORT_CMD:  prdata = cmd_n_q;
        swio_pkg::PORT_VDIP: prdata = virt_byte;
        swio_pkg::PORT_LOCK: prdata = lock_byte;
        swio_pkg::PORT_LED:  prdata = led_q;
        swio_pkg::PORT_PDIP: prdata = dip_sw;
        default: ;
      endcase
    end
  end

  // Setup phase holds its address into the access phase
  a_addr_stable: assert property (@(posedge clock_bus) disable iff (warmRESET)
    (apb.psel && !apb.penable) |=> $stable(apb.paddr));

endmodule

`default_nettype wire

/* verilog/swio_dip_cell.sv */
`timescale 1ns/1ps
`default_nettype none

module swio_dip_cell (
  input  wire logic                  clock_bus,
  input  wire logic                  warmRESET,
  input  wire swio_pkg::cell_ctrl_t  ctrl,
  input  wire logic                  phys,       // Physical DIP switch
  output swio_pkg::cell_state_t      state
);

  logic virt_q;   // Virtual switch value
  logic ack_q;    // Last physical value taken over
  logic lock_q;
  logic follow;

  // Physical switch moved while unlocked
  assign follow = (phys != ack_q) && !lock_q;

  always_ff @(posedge clock_bus) begin
    if (warmRESET) begin
      virt_q <= phys;                                // Cold start mirrors the DIP
      ack_q  <= phys;
      lock_q <= 1'b0;
    end else begin
      if (ctrl.restore) begin
        virt_q <= phys;
        ack_q  <= phys;
      end else if (ctrl.set_virt) begin
        virt_q <= ctrl.virt_val;                     // Physical change waits a cycle
      end else if (follow) begin
        virt_q <= phys;
        ack_q  <= phys;
      end
      if (ctrl.set_lock) begin
        lock_q <= ctrl.lock_val;
      end
    end
  end

  assign state.virt = virt_q;
  assign state.lock = lock_q;

  // Restore and a port 2 write come from different commands
  a_ctrl_excl: assert property (@(posedge clock_bus) disable iff (warmRESET)
    !(ctrl.restore && ctrl.set_virt));

endmodule

`default_nettype wire

/* verilog/swio_reset_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module swio_reset_ctrl (
  input  wire logic                                          clock_bus,
  input  wire logic                                          warmRESET,
  input  wire logic [swio_pkg::DATA_W-1:0]                   dip_sw,
  input  wire swio_pkg::cell_state_t [swio_pkg::NUM_SW-1:0]  cell_state,
  input  wire logic                                          warm_req,
  output logic [swio_pkg::DATA_W-1:0]                        virt_dip,
  output logic [swio_pkg::DATA_W-1:0]                        lock_mask,
  output logic                                               sys_warm_reset,
  output logic                                               rst_req_sta,
  output logic                                               mapper_mode,
  output logic                                               megasd_mode
);

  // Drain the cells into bytes
  always_comb begin
    for (int i = 0; i < swio_pkg::NUM_SW; i++) begin
      virt_dip[i]  = cell_state[i].virt;
      lock_mask[i] = cell_state[i].lock;
    end
  end

  always_ff @(posedge clock_bus) begin
    if (warmRESET) begin
      sys_warm_reset <= 1'b0;
      rst_req_sta    <= 1'b0;
      mapper_mode    <= dip_sw[swio_pkg::BIT_MAPPER];
      megasd_mode    <= dip_sw[swio_pkg::BIT_MEGASD];
    end else begin
      sys_warm_reset <= warm_req;                       // One cycle after the command
      if (sys_warm_reset) begin
        mapper_mode <= virt_dip[swio_pkg::BIT_MAPPER];   // Requests take effect here
        megasd_mode <= virt_dip[swio_pkg::BIT_MEGASD];
      end
      rst_req_sta <= (virt_dip[swio_pkg::BIT_MAPPER] != mapper_mode) ||
                     (virt_dip[swio_pkg::BIT_MEGASD] != megasd_mode);
    end
  end

  // A warm reset pulse is a single cycle
  a_warm_pulse: assert property (@(posedge clock_bus) disable iff (warmRESET)
    sys_warm_reset |=> !sys_warm_reset);

endmodule

`default_nettype wire

/* verilog/swio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module swio_top (
  input  wire logic                         clock_bus,
  input  wire logic                         warmRESET,
  input  wire swio_pkg::apb_req_t           apb_req,
  input  wire logic [swio_pkg::DATA_W-1:0]  dip_sw,
  output logic [swio_pkg::DATA_W-1:0]       prdata,
  output logic [swio_pkg::DATA_W-1:0]       virt_dip,
  output logic [swio_pkg::DATA_W-1:0]       lock_mask,
  output logic [swio_pkg::DATA_W-1:0]       led_mask,
  output logic                              sys_warm_reset,
  output logic                              rst_req_sta,
  output logic                              mapper_mode,
  output logic                              megasd_mode
);

  swio_pkg::cell_ctrl_t  [swio_pkg::NUM_SW-1:0] cell_ctrl;
  swio_pkg::cell_state_t [swio_pkg::NUM_SW-1:0] cell_state;
  logic                                         warm_req;

  // Bus decode and command registers
  swio_apb_port u_apb_port (
    .clock_bus  (clock_bus),
    .warmRESET  (warmRESET),
    .apb        (apb_req),
    .dip_sw     (dip_sw),
    .cell_state (cell_state),
    .prdata     (prdata),
    .cell_ctrl  (cell_ctrl),
    .warm_req   (warm_req),
    .led_mask   (led_mask)
  );

  // One cell per DIP switch
  for (genvar g = 0; g < swio_pkg::NUM_SW; g++) begin : g_cell
    swio_dip_cell u_cell (
      .clock_bus (clock_bus),
      .warmRESET (warmRESET),
      .ctrl      (cell_ctrl[g]),
      .phys      (dip_sw[g]),
      .state     (cell_state[g])
    );
  end

  swio_reset_ctrl u_reset_ctrl (
    .clock_bus      (clock_bus),
    .warmRESET      (warmRESET),
    .dip_sw         (dip_sw),
    .cell_state     (cell_state),
    .warm_req       (warm_req),
    .virt_dip       (virt_dip),
    .lock_mask      (lock_mask),
    .sys_warm_reset (sys_warm_reset),
    .rst_req_sta    (rst_req_sta),
    .mapper_mode    (mapper_mode),
    .megasd_mode    (megasd_mode)
  );

endmodule

`default_nettype wire

/* sim/swio_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module swio_tb;

  localparam int RESET_CYCLES = 4;
  localparam int NUM_XFERS    = 19;   // APB transfers in the sequence below
  localparam int XFER_CYCLES  = 4;    // Setup, access, idle, with slack
  localparam int SETTLE_CYCLES = 8;   // Extra edges waited on outside transfers
  localparam int TEST_CYCLES  = RESET_CYCLES + NUM_XFERS * XFER_CYCLES + SETTLE_CYCLES;
  localparam int WATCHDOG_CYCLES = 5 * TEST_CYCLES;

  logic                   clock_bus;
  logic                   warmRESET;
  swio_pkg::apb_req_t     apb_req;
  logic [7:0]             dip_sw;
  logic [7:0]             prdata;
  logic [7:0]             virt_dip;
  logic [7:0]             lock_mask;
  logic [7:0]             led_mask;
  logic                   sys_warm_reset;
  logic                   rst_req_sta;
  logic                   mapper_mode;
  logic                   megasd_mode;

  // Reference model
  logic [7:0] exp_virt;
  logic [7:0] exp_lock;
  logic [7:0] exp_led;
  logic       exp_mapper;
  logic       exp_megasd;
  int         errors = 0;
  int         seed = 32'he3de_29ef;

  swio_top dut_i (
    .clock_bus, .warmRESET, .apb_req, .dip_sw, .prdata, .virt_dip, .lock_mask,
    .led_mask, .sys_warm_reset, .rst_req_sta, .mapper_mode, .megasd_mode
  );

  always #20 clock_bus = ~clock_bus;   // 40 ns period

  function automatic void report_mismatch(input string name, input logic [7:0] got,
                                          input logic [7:0] exp);
    errors++;
    $display("ERROR %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
  endfunction

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  // One zero-wait transfer; returns with the ending edge just taken
  task automatic apb_xfer(input logic write, input logic [swio_pkg::PORT_W-1:0] addr,
                          input logic [7:0] data, output logic [7:0] rdata);
    @(posedge clock_bus);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
    @(posedge clock_bus);
    apb_req.penable <= 1'b1;
    @(negedge clock_bus);
    rdata = prdata;                   // Combinational read, settled mid access
    @(posedge clock_bus);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [swio_pkg::PORT_W-1:0] addr, input logic [7:0] data);
    logic [7:0] unused;
    apb_xfer(1'b1, addr, data, unused);
  endtask

  task automatic apb_read_check(input logic [swio_pkg::PORT_W-1:0] addr,
                                input logic [7:0] exp, input string name);
    logic [7:0] got;
    apb_xfer(1'b0, addr, 8'h00, got);
    check_byte(name, got, exp);
  endtask

  // Continuous comparison against the model, mid cycle
  a_virt: assert property (@(negedge clock_bus) disable iff (warmRESET)
    virt_dip == exp_virt) else report_mismatch("virt_dip", virt_dip, exp_virt);
  a_lock: assert property (@(negedge clock_bus) disable iff (warmRESET)
    lock_mask == exp_lock) else report_mismatch("lock_mask", lock_mask, exp_lock);
  a_led: assert property (@(negedge clock_bus) disable iff (warmRESET)
    led_mask == exp_led) else report_mismatch("led_mask", led_mask, exp_led);
  a_modes: assert property (@(negedge clock_bus) disable iff (warmRESET)
    {mapper_mode, megasd_mode} == {exp_mapper, exp_megasd})
    else report_mismatch("{mapper_mode,megasd_mode}", {6'd0, mapper_mode, megasd_mode},
                         {6'd0, exp_mapper, exp_megasd});

  initial begin
    logic [7:0] data;
    clock_bus = 1'b0;
    warmRESET = 1'b1;
    apb_req   = '0;
    dip_sw    = 8'($random(seed));
    exp_virt  = dip_sw;                // Cold reset mirrors the DIP
    exp_lock  = '0;
    exp_led   = '0;
    exp_mapper = dip_sw[swio_pkg::BIT_MAPPER];
    exp_megasd = dip_sw[swio_pkg::BIT_MEGASD];
    repeat (RESET_CYCLES) @(posedge clock_bus);
    warmRESET <= 1'b0;

    // ID select, then a closed window under ID 008
    apb_write(swio_pkg::PORT_ID, 8'hD4);
    apb_read_check(swio_pkg::PORT_ID, 8'h2B, "prdata port 0");
    apb_write(swio_pkg::PORT_ID, 8'h08);
    apb_read_check(swio_pkg::PORT_ID, 8'hF7, "prdata port 0");
    apb_write(swio_pkg::PORT_VDIP, 8'($random(seed)));   // Must be ignored
    apb_read_check(swio_pkg::PORT_VDIP, 8'hFF, "prdata port 2");
    apb_write(swio_pkg::PORT_ID, 8'hD4);

    // Virtual switches, stored inverted
    data = 8'($random(seed));
    apb_write(swio_pkg::PORT_VDIP, data);
    exp_virt = ~data;
    apb_read_check(swio_pkg::PORT_VDIP, ~data, "prdata port 2");

    // Command 44 locks display bit 1
    apb_write(swio_pkg::PORT_CMD, swio_pkg::CMD_LOCK_BASE + 8'd3);
    exp_lock[1] = 1'b1;
    apb_read_check(swio_pkg::PORT_LOCK, exp_lock, "prdata port 3");
    @(posedge clock_bus);
    dip_sw <= ~dip_sw;                 // Flip every physical switch
    @(posedge clock_bus);              // Unlocked cells follow on this edge
    exp_virt = (exp_virt & exp_lock) | (dip_sw & ~exp_lock);
    apb_read_check(swio_pkg::PORT_PDIP, dip_sw, "prdata port 0xC");

    // No request while bits 6 and 7 match the applied modes
    data = 8'($random(seed));
    data[swio_pkg::BIT_MAPPER] = ~exp_mapper;  // Stored inverted, equal to the mode
    data[swio_pkg::BIT_MEGASD] = ~exp_megasd;
    apb_write(swio_pkg::PORT_VDIP, data);
    exp_virt = ~data;
    @(posedge clock_bus);
    @(negedge clock_bus);
    check_byte("rst_req_sta", {7'd0, rst_req_sta}, 8'h00);

    // Pending request, then warm reset with the 4 MB mapper
    data[swio_pkg::BIT_MEGASD] = exp_megasd;   // Only bit 7 moves off its mode
    apb_write(swio_pkg::PORT_VDIP, data);
    exp_virt = ~data;
    @(posedge clock_bus);
    @(negedge clock_bus);
    check_byte("rst_req_sta", {7'd0, rst_req_sta}, 8'h01);
    apb_write(swio_pkg::PORT_CMD, swio_pkg::CMD_MAP4M_RST);
    exp_virt[swio_pkg::BIT_MAPPER] = 1'b1;
    @(negedge clock_bus);
    check_byte("sys_warm_reset", {7'd0, sys_warm_reset}, 8'h01);
    @(posedge clock_bus);              // Modes load with the pulse
    exp_mapper = 1'b1;
    exp_megasd = exp_virt[swio_pkg::BIT_MEGASD];
    @(negedge clock_bus);
    check_byte("sys_warm_reset", {7'd0, sys_warm_reset}, 8'h00);
    @(posedge clock_bus);
    @(negedge clock_bus);
    check_byte("rst_req_sta", {7'd0, rst_req_sta}, 8'h00);

    // LED mask, then restore
    data = 8'($random(seed));
    apb_write(swio_pkg::PORT_LED, data);
    exp_led = ~data;
    apb_read_check(swio_pkg::PORT_LED, ~data, "prdata port 4");
    apb_write(swio_pkg::PORT_CMD, swio_pkg::CMD_RESTORE);
    exp_virt = dip_sw;
    exp_lock = '0;
    exp_led  = '0;
    apb_read_check(swio_pkg::PORT_CMD, 8'h00, "prdata port 1");
    @(negedge clock_bus);
    @(posedge clock_bus);              // Last mid-cycle compare has reported

    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock_bus);
    $display("Timeout after %0d cycles, sequence did not finish, %0d errors so far",
             WATCHDOG_CYCLES, errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
verilog/swio_pkg.sv
verilog/swio_apb_port.sv
verilog/swio_dip_cell.sv
verilog/swio_reset_ctrl.sv
verilog/swio_top.sv
sim/swio_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the switched-I/O testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module swio_tb -f flist.f -o swio_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/swio_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation binary exited with status $status"
  exit 1
fi

echo "$out" | grep -qx "Simulation passed" || exit 1
exit 0
